// File: hw/dnc_format_pkg.sv
////////////////////////////////////////
// Fixed-point format for the output
// vector datapath
// Signed Q8.8 elements, a wide row
// accumulator and the clamp back to
// element range, shared by the product
// units and the output adder
////////////////////////////////////////

package dnc_format_pkg;

  // Element format
  localparam int data_width = 16;
  localparam int frac_bits  = 8;

  // Full 32-bit products plus headroom for the row sum
  localparam int acc_width = 40;

  typedef logic signed [data_width-1:0] data_t;
  typedef logic signed [acc_width-1:0]  acc_t;

  // Saturation limits
  localparam data_t data_max = data_t'({1'b0, {(data_width - 1){1'b1}}});
  localparam data_t data_min = data_t'({1'b1, {(data_width - 1){1'b0}}});

  // Clamp a wide signed value into element range
  function automatic data_t saturate(input acc_t value);
    data_t result;
    if (value > acc_t'(data_max)) begin
      result = data_max;
    end else if (value < acc_t'(data_min)) begin
      result = data_min;
    end else begin
      result = data_t'(value);
    end
    return result;
  endfunction

  // Row sum back to Q8.8
  // arithmetic shift drops the fraction, so negative sums round down
  function automatic data_t round_saturate(input acc_t sum);
    return saturate(sum >>> frac_bits);
  endfunction

endpackage

// File: hw/dnc_shape_pkg.sv
////////////////////////////////////////
// Dimension limits of the output vector
// job and the counter types sized from
// them
// Sizes outside 1..limit are not handled
////////////////////////////////////////

package dnc_shape_pkg;

  // Largest Y
  localparam int max_rows = 16;

  // Largest R*W and largest L, also the vector buffer depth
  localparam int max_cols = 32;

  // Holds 1 up to max_cols
  localparam int size_width = 6;

  // Buffer address bits
  localparam int index_width = $clog2(max_cols);

  // Job sizes and row counters
  typedef logic [size_width-1:0] size_t;

  // Vector buffer address and column counter
  typedef logic [index_width-1:0] index_t;

endpackage

// File: hw/dnc_matrix_vector_product.sv
////////////////////////////////////////
// Matrix-vector product unit
// Takes the whole vector into a local
// buffer, then streams the matrix row
// by row and emits one saturated Q8.8
// dot product per row on the res stream
////////////////////////////////////////

module dnc_matrix_vector_product
  import dnc_format_pkg::*;
  import dnc_shape_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Job control, sampled while idle
  input  logic  start,
  input  size_t rows,
  input  size_t cols,

  // Vector stream, cols elements
  input  data_t vec_data,
  input  logic  vec_valid,
  output logic  vec_ready,

  // Matrix stream, row-major
  input  data_t mat_data,
  input  logic  mat_valid,
  output logic  mat_ready,

  // Row results
  output data_t res_data,
  output logic  res_last,
  output logic  res_valid,
  input  logic  res_ready
);

  ////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    st_idle,
    st_load,
    st_stream,
    st_drain
  } state_t;

  state_t state;

  // Latched job sizes
  size_t  rows_q;
  size_t  cols_q;

  // Position in the job
  size_t  row_idx;
  index_t col_idx;

  // Vector storage
  data_t  vec_buf [max_cols];

  // Accumulation
  acc_t   acc;
  acc_t   product;
  acc_t   acc_sum;

  logic   col_last;
  logic   row_last;
  logic   res_free;
  logic   vec_fire;
  logic   mat_fire;
  logic   res_fire;

  ////////////////////////////////////////
  // Handshakes
  ////////////////////////////////////////

  assign col_last = (col_idx == index_t'(cols_q - 1'b1));
  assign row_last = (row_idx == rows_q - 1'b1);

  // Result slot empty now or emptied this cycle
  assign res_free = !res_valid || res_ready;

  // Vector first, matrix only once the buffer is full
  assign vec_ready = (state == st_load);

  // Row end needs the result slot, other columns never stall
  assign mat_ready = (state == st_stream) && (!col_last || res_free);

  assign vec_fire = vec_valid && vec_ready;
  assign mat_fire = mat_valid && mat_ready;
  assign res_fire = res_valid && res_ready;

  ////////////////////////////////////////
  // Multiply-accumulate
  ////////////////////////////////////////

  // Full-width product against the buffered element of this column
  assign product = acc_t'(mat_data) * acc_t'(vec_buf[col_idx]);
  assign acc_sum = acc + product;

  // Vector buffer write, column counter doubles as address
  always_ff @(posedge CLK) begin
    if (vec_fire) begin
      vec_buf[col_idx] <= vec_data;
    end
  end

  ////////////////////////////////////////
  // Sequencing
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= st_idle;
      rows_q  <= '0;
      cols_q  <= '0;
      row_idx <= '0;
      col_idx <= '0;
      acc     <= '0;
    end else begin
      case (state)
        st_idle: begin
          if (start) begin
            rows_q  <= rows;
            cols_q  <= cols;
            row_idx <= '0;
            col_idx <= '0;
            acc     <= '0;
            state   <= st_load;
          end
        end

        st_load: begin
          if (vec_fire) begin
            if (col_last) begin
              col_idx <= '0;
              state   <= st_stream;
            end else begin
              col_idx <= col_idx + 1'b1;
            end
          end
        end

        st_stream: begin
          if (mat_fire) begin
            if (col_last) begin
              // Row done, next row starts from zero
              col_idx <= '0;
              acc     <= '0;
              if (row_last) begin
                state <= st_drain;
              end else begin
                row_idx <= row_idx + 1'b1;
              end
            end else begin
              col_idx <= col_idx + 1'b1;
              acc     <= acc_sum;
            end
          end
        end

        // Wait for the final row to leave
        st_drain: begin
          if (res_fire && res_last) begin
            state <= st_idle;
          end
        end

        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Result register
  ////////////////////////////////////////

  // One entry, refilled on the same edge it empties
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      res_valid <= 1'b0;
      res_last  <= 1'b0;
    end else if (mat_fire && col_last) begin
      res_valid <= 1'b1;
      res_last  <= row_last;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  // Shifted and clamped row sum
  always_ff @(posedge CLK) begin
    if (mat_fire && col_last) begin
      res_data <= round_saturate(acc_sum);
    end
  end

endmodule

// File: hw/dnc_vector_adder.sv
////////////////////////////////////////
// Element-wise saturating adder
// Joins two row-result streams with no
// storage and no added latency
// Both inputs end on the same element,
// so last comes from stream a
////////////////////////////////////////

module dnc_vector_adder
  import dnc_format_pkg::*;
(
  // First operand stream
  input  data_t a_data,
  input  logic  a_last,
  input  logic  a_valid,
  output logic  a_ready,

  // Second operand stream
  input  data_t b_data,
  input  logic  b_valid,
  output logic  b_ready,

  // Sum stream
  output data_t sum_data,
  output logic  sum_last,
  output logic  sum_valid,
  input  logic  sum_ready
);

  ////////////////////////////////////////
  // Join
  ////////////////////////////////////////

  // Widened operands and raw sum
  acc_t a_wide;
  acc_t b_wide;
  acc_t sum_wide;

  // Output only when both sides hold an element
  assign sum_valid = a_valid && b_valid;

  // Each side pops only together with the other
  assign a_ready = sum_ready && b_valid;
  assign b_ready = sum_ready && a_valid;

  // Row markers line up, a carries the flag
  assign sum_last = a_last;

  ////////////////////////////////////////
  // Saturating add
  ////////////////////////////////////////

  // Sign-extend before adding, no wrap
  assign a_wide   = acc_t'(a_data);
  assign b_wide   = acc_t'(b_data);
  assign sum_wide = a_wide + b_wide;

  // Clamp back to Q8.8 range
  assign sum_data = saturate(sum_wide);

endmodule

// File: hw/dnc_output_vector.sv
////////////////////////////////////////
// Output vector of the DNC controller
// y = K*r + U*h in signed Q8.8
// Start a job with start and the sizes
// while busy is low, feed k, r, u and h,
// collect y until last; done pulses one
// cycle after the final y transfer
////////////////////////////////////////

module dnc_output_vector
  import dnc_format_pkg::*;
  import dnc_shape_pkg::*;
(
  input  logic  CLK,
  input  logic  RST,

  // Job start
  input  logic  start,
  input  size_t size_y,
  input  size_t size_rw,
  input  size_t size_l,

  // K matrix, row-major
  input  data_t k_data,
  input  logic  k_valid,
  output logic  k_ready,

  // Flattened read vector
  input  data_t r_data,
  input  logic  r_valid,
  output logic  r_ready,

  // U matrix, row-major
  input  data_t u_data,
  input  logic  u_valid,
  output logic  u_ready,

  // Hidden state
  input  data_t h_data,
  input  logic  h_valid,
  output logic  h_ready,

  // Output vector
  output data_t y_data,
  output logic  y_last,
  output logic  y_valid,
  input  logic  y_ready,

  // Status
  output logic  busy,
  output logic  done
);

  ////////////////////////////////////////
  // Declarations
  ////////////////////////////////////////

  typedef enum logic {
    ctl_idle,
    ctl_running
  } ctl_state_t;

  ctl_state_t ctl_state;

  // Pulse to both product units
  logic  unit_start;

  // Job sizes held for the units
  size_t size_y_q;
  size_t size_rw_q;
  size_t size_l_q;

  // K*r row results
  data_t kr_data;
  logic  kr_last;
  logic  kr_valid;
  logic  kr_ready;

  // U*h row results
  data_t uh_data;
  logic  uh_valid;
  logic  uh_ready;

  logic  y_fire;

  ////////////////////////////////////////
  // Job controller
  ////////////////////////////////////////

  assign busy   = (ctl_state == ctl_running);
  assign y_fire = y_valid && y_ready;

  // Start only while idle, a start during a job is dropped
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      ctl_state  <= ctl_idle;
      unit_start <= 1'b0;
      done       <= 1'b0;
    end else begin
      unit_start <= 1'b0;
      done       <= 1'b0;
      case (ctl_state)
        ctl_idle: begin
          if (start) begin
            ctl_state  <= ctl_running;
            unit_start <= 1'b1;
          end
        end
        ctl_running: begin
          // Job ends on the final y element
          if (y_fire && y_last) begin
            ctl_state <= ctl_idle;
            done      <= 1'b1;
          end
        end
        default: begin
          ctl_state <= ctl_idle;
        end
      endcase
    end
  end

  // Size capture on job acceptance
  always_ff @(posedge CLK) begin
    if (start && !busy) begin
      size_y_q  <= size_y;
      size_rw_q <= size_rw;
      size_l_q  <= size_l;
    end
  end

  ////////////////////////////////////////
  // Product units, run side by side
  ////////////////////////////////////////

  // K is Y by R*W against r
  dnc_matrix_vector_product kr_product (
    .CLK       (CLK),
    .RST       (RST),
    .start     (unit_start),
    .rows      (size_y_q),
    .cols      (size_rw_q),
    .vec_data  (r_data),
    .vec_valid (r_valid),
    .vec_ready (r_ready),
    .mat_data  (k_data),
    .mat_valid (k_valid),
    .mat_ready (k_ready),
    .res_data  (kr_data),
    .res_last  (kr_last),
    .res_valid (kr_valid),
    .res_ready (kr_ready)
  );

  // U is Y by L against h, last mirrors kr
  dnc_matrix_vector_product uh_product (
    .CLK       (CLK),
    .RST       (RST),
    .start     (unit_start),
    .rows      (size_y_q),
    .cols      (size_l_q),
    .vec_data  (h_data),
    .vec_valid (h_valid),
    .vec_ready (h_ready),
    .mat_data  (u_data),
    .mat_valid (u_valid),
    .mat_ready (u_ready),
    .res_data  (uh_data),
    .res_last  (),
    .res_valid (uh_valid),
    .res_ready (uh_ready)
  );

  ////////////////////////////////////////
  // Output join
  ////////////////////////////////////////

  dnc_vector_adder output_adder (
    .a_data    (kr_data),
    .a_last    (kr_last),
    .a_valid   (kr_valid),
    .a_ready   (kr_ready),
    .b_data    (uh_data),
    .b_valid   (uh_valid),
    .b_ready   (uh_ready),
    .sum_data  (y_data),
    .sum_last  (y_last),
    .sum_valid (y_valid),
    .sum_ready (y_ready)
  );

endmodule

// File: testbench/dnc_output_vector_tb.sv
////////////////////////////////////////
// Testbench for the DNC output vector
// Runs hand-picked, random and saturating
// jobs through the DUT with LFSR-driven
// valid gaps and y back-pressure, and
// checks every y element against a
// software model of y = K*r + U*h
////////////////////////////////////////

module dnc_output_vector_tb
  import dnc_format_pkg::*;
  import dnc_shape_pkg::*;
();

  ////////////////////////////////////////
  // Run length and limits
  ////////////////////////////////////////

  // Hand job, forty random jobs and three saturating jobs
  localparam int     num_jobs       = 44;
  localparam longint timeout_cycles = num_jobs * (max_rows * max_cols * 2 + 50) * 8;
  localparam int     stream_depth   = max_rows * max_cols;

  // Stream slot numbers of k, r, u and h
  localparam int s_k = 0;
  localparam int s_r = 1;
  localparam int s_u = 2;
  localparam int s_h = 3;

  ////////////////////////////////////////
  // DUT signals
  ////////////////////////////////////////

  logic        CLK;
  logic        RST;
  logic        start;
  size_t       size_y;
  size_t       size_rw;
  size_t       size_l;
  data_t       in_data [4];
  logic  [3:0] in_valid;
  wire   [3:0] in_ready;
  data_t       y_data;
  logic        y_last;
  logic        y_valid;
  logic        y_ready;
  logic        busy;
  logic        done;

  // Job data and bookkeeping
  data_t       stim_mem [4][stream_depth];
  int          stim_len [4];
  logic [16:0] exp_q [$];
  logic [31:0] rng [6];
  int          job_seq;
  int          y_count;
  int          check_count;
  int          error_count;
  logic        gaps_on;
  logic        bp_on;

  dnc_output_vector dnc_output_vector_i (
    .CLK     (CLK),
    .RST     (RST),
    .start   (start),
    .size_y  (size_y),
    .size_rw (size_rw),
    .size_l  (size_l),
    .k_data  (in_data[s_k]),
    .k_valid (in_valid[s_k]),
    .k_ready (in_ready[s_k]),
    .r_data  (in_data[s_r]),
    .r_valid (in_valid[s_r]),
    .r_ready (in_ready[s_r]),
    .u_data  (in_data[s_u]),
    .u_valid (in_valid[s_u]),
    .u_ready (in_ready[s_u]),
    .h_data  (in_data[s_h]),
    .h_valid (in_valid[s_h]),
    .h_ready (in_ready[s_h]),
    .y_data  (y_data),
    .y_last  (y_last),
    .y_valid (y_valid),
    .y_ready (y_ready),
    .busy    (busy),
    .done    (done)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  ////////////////////////////////////////
  // Random numbers
  ////////////////////////////////////////

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] state);
    return {1'b0, state[31:1]} ^ (state[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One step per bit and a separate state per consumer
  function automatic logic [31:0] rand_bits(input int src, input int n);
    logic [31:0] bits;
    int          i;
    bits = '0;
    for (i = 0; i < n; i++) begin
      rng[src] = lfsr_step(rng[src]);
      bits = {bits[30:0], rng[src][0]};
    end
    return bits;
  endfunction

  // Signed value of w bits sign-extended into Q8.8
  function automatic data_t rand_data(input int w);
    logic signed [31:0] v;
    v = rand_bits(0, w) << (32 - w);
    return data_t'(v >>> (32 - w));
  endfunction

  ////////////////////////////////////////
  // Reference model and checks
  ////////////////////////////////////////

  function automatic longint clamp_q88(input longint v);
    if (v > longint'(data_max)) begin
      return longint'(data_max);
    end
    if (v < longint'(data_min)) begin
      return longint'(data_min);
    end
    return v;
  endfunction

  // Shift and clamp both dot products before the clamped sum
  function automatic data_t expected_y(input int row, input int nrw, input int nl);
    longint kr;
    longint uh;
    int     j;
    kr = 0;
    uh = 0;
    for (j = 0; j < nrw; j++) begin
      kr += longint'(stim_mem[s_k][row * nrw + j]) * longint'(stim_mem[s_r][j]);
    end
    for (j = 0; j < nl; j++) begin
      uh += longint'(stim_mem[s_u][row * nl + j]) * longint'(stim_mem[s_h][j]);
    end
    return data_t'(clamp_q88(clamp_q88(kr >>> frac_bits) + clamp_q88(uh >>> frac_bits)));
  endfunction

  task automatic compare(input string what, input logic [31:0] actual,
                         input logic [31:0] expected);
    check_count++;
    if (actual !== expected) begin
      error_count++;
      $display("Fail at time %0t: %s = 0x%0h, expected 0x%0h", $time, what, actual,
               expected);
    end
  endtask

  ////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////

  // One sender per input stream woken by each new job
  task automatic feed_stream(input int s);
    int idx;
    int seen;
    bit fired;
    seen = 0;
    forever begin
      do @(posedge CLK); while (job_seq == seen);
      seen = job_seq;
      idx = 0;
      fired = 1'b0;
      while (idx < stim_len[s]) begin
        @(negedge CLK);
        if (fired) begin
          in_valid[s] = 1'b0;
        end
        // Optional idle cycle before the next element
        if (!in_valid[s] && (!gaps_on || rand_bits(s + 1, 2) != 0)) begin
          in_data[s]  = stim_mem[s][idx];
          in_valid[s] = 1'b1;
        end
        @(posedge CLK);
        fired = in_valid[s] && in_ready[s];
        if (fired) begin
          idx++;
        end
      end
      @(negedge CLK);
      in_valid[s] = 1'b0;
    end
  endtask

  initial begin
    fork
      feed_stream(s_k);
      feed_stream(s_r);
      feed_stream(s_u);
      feed_stream(s_h);
    join
  end

  // Consumer side is ready about half the time under stress
  initial begin
    @(negedge RST);
    forever begin
      @(negedge CLK);
      y_ready = bp_on ? rand_bits(5, 1) != 0 : 1'b1;
    end
  end

  task automatic fill_random(input int s, input int n, input int w);
    int i;
    for (i = 0; i < n; i++) begin
      stim_mem[s][i] = rand_data(w);
    end
  endtask

  task automatic fill_constant(input int s, input int n, input data_t value);
    int i;
    for (i = 0; i < n; i++) begin
      stim_mem[s][i] = value;
    end
  endtask

  // Queue expected y, start the job, optionally poke start mid-job, wait for done
  task automatic run_job(input int ny, input int nrw, input int nl, input bit stress,
                         input bit extra_start);
    int row;
    stim_len[s_k] = ny * nrw;
    stim_len[s_r] = nrw;
    stim_len[s_u] = ny * nl;
    stim_len[s_h] = nl;
    for (row = 0; row < ny; row++) begin
      exp_q.push_back({row == ny - 1, expected_y(row, nrw, nl)});
    end
    y_count = 0;
    @(posedge CLK);
    gaps_on = stress;
    bp_on   = stress;
    @(negedge CLK);
    size_y  = size_t'(ny);
    size_rw = size_t'(nrw);
    size_l  = size_t'(nl);
    start   = 1'b1;
    job_seq++;
    @(negedge CLK);
    start = 1'b0;
    compare("busy after start", 32'(busy), 1);
    if (extra_start) begin
      // Different sizes that must not reach the running job
      @(negedge CLK);
      compare("busy at ignored start", 32'(busy), 1);
      size_y  = size_t'(int'(rand_bits(0, 4)) + 1);
      size_rw = size_t'(int'(rand_bits(0, 5)) + 1);
      size_l  = size_t'(int'(rand_bits(0, 5)) + 1);
      start   = 1'b1;
      @(negedge CLK);
      start = 1'b0;
    end
    while (!done) begin
      @(negedge CLK);
    end
    compare("y elements in job", y_count, ny);
    compare("y elements still expected", exp_q.size(), 0);
  endtask

  ////////////////////////////////////////
  // Comparator
  ////////////////////////////////////////

  initial begin : compare_y
    logic [16:0] want;
    forever begin
      @(posedge CLK);
      if (y_valid && y_ready) begin
        y_count++;
        compare("busy at y transfer", 32'(busy), 1);
        compare("done at y transfer", 32'(done), 0);
        if (exp_q.size() == 0) begin
          error_count++;
          $display("Error at time %0t: y element arrived with none expected", $time);
        end else begin
          want = exp_q.pop_front();
          compare("y_data", {16'h0, y_data}, {16'h0, want[15:0]});
          compare("y_last", 32'(y_last), 32'(want[16]));
        end
        // done pulses one cycle after the final transfer and busy drops with it
        if (y_last) begin
          @(negedge CLK);
          compare("done after last y", 32'(done), 1);
          compare("busy after last y", 32'(busy), 0);
          @(negedge CLK);
          compare("done one cycle later", 32'(done), 0);
        end
      end
    end
  end

  ////////////////////////////////////////
  // Watchdog
  ////////////////////////////////////////

  initial begin : watchdog
    #(timeout_cycles * 20);
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    $display("Testbench failed");
    $finish;
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int i;
    int j;
    int ny;
    int nrw;
    int nl;
    RST         = 1'b1;
    start       = 1'b0;
    size_y      = '0;
    size_rw     = '0;
    size_l      = '0;
    in_valid    = '0;
    y_ready     = 1'b0;
    gaps_on     = 1'b0;
    bp_on       = 1'b0;
    job_seq     = 0;
    y_count     = 0;
    check_count = 0;
    error_count = 0;
    for (i = 0; i < 4; i++) begin
      in_data[i]  = '0;
      stim_len[i] = 0;
    end
    // Seed the stream, gap and ready generators from the main one
    rng[0] = 32'h6a5b_13ac;
    for (i = 1; i < 6; i++) begin
      rng[i] = rand_bits(0, 32) | 32'h1;
    end

    repeat (5) @(posedge CLK);
    @(negedge CLK);
    RST = 1'b0;
    @(negedge CLK);

    // Quiet after reset
    compare("busy after reset", 32'(busy), 0);
    compare("done after reset", 32'(done), 0);
    compare("y_valid after reset", 32'(y_valid), 0);
    compare("k_ready after reset", 32'(in_ready[s_k]), 0);
    compare("r_ready after reset", 32'(in_ready[s_r]), 0);
    compare("u_ready after reset", 32'(in_ready[s_u]), 0);
    compare("h_ready after reset", 32'(in_ready[s_h]), 0);

    // Hand job giving y = {0.25, 7.75}
    stim_mem[s_k][0] = 16'sh0100;
    stim_mem[s_k][1] = 16'shfe00;
    stim_mem[s_k][2] = 16'sh0080;
    stim_mem[s_k][3] = 16'sh0040;
    stim_mem[s_k][4] = 16'sh0300;
    stim_mem[s_k][5] = 16'shfe80;
    stim_mem[s_r][0] = 16'sh0200;
    stim_mem[s_r][1] = 16'sh0080;
    stim_mem[s_r][2] = 16'shfc00;
    stim_mem[s_u][0] = 16'sh0180;
    stim_mem[s_u][1] = 16'shff00;
    stim_mem[s_u][2] = 16'shff40;
    stim_mem[s_u][3] = 16'sh0200;
    stim_mem[s_h][0] = 16'sh0100;
    stim_mem[s_h][1] = 16'sh0040;
    run_job(2, 3, 2, 1'b0, 1'b0);

    // Random jobs with a sweep of element widths so some rows clamp
    // Second half adds valid gaps and y back-pressure
    for (j = 0; j < 40; j++) begin
      ny  = int'(rand_bits(0, 4)) + 1;
      nrw = int'(rand_bits(0, 5)) + 1;
      nl  = int'(rand_bits(0, 5)) + 1;
      fill_random(s_k, ny * nrw, 6 + j % 11);
      fill_random(s_r, nrw, 6 + j % 11);
      fill_random(s_u, ny * nl, 6 + j % 11);
      fill_random(s_h, nl, 6 + j % 11);
      run_job(ny, nrw, nl, j >= 20, j % 5 == 2);
    end

    // Both products and the sum clamp high
    fill_constant(s_k, 4 * max_cols, data_max);
    fill_constant(s_r, max_cols, data_max);
    fill_constant(s_u, 4 * max_cols, data_max);
    fill_constant(s_h, max_cols, data_max);
    run_job(4, max_cols, max_cols, 1'b1, 1'b0);

    // Both products and the sum clamp low
    fill_constant(s_k, 4 * max_cols, data_min);
    fill_constant(s_u, 4 * max_cols, data_max);
    fill_constant(s_h, max_cols, data_min);
    run_job(4, max_cols, max_cols, 1'b1, 1'b0);

    // Products in range and only the final add clamps
    fill_constant(s_k, 3, data_max);
    fill_constant(s_r, 1, 16'sh0100);
    fill_constant(s_u, 3, data_max);
    fill_constant(s_h, 1, 16'sh0100);
    run_job(3, 1, 1, 1'b1, 1'b0);

    repeat (4) @(negedge CLK);
    $display("Checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

// File: dnc_output_vector.f
hw/dnc_format_pkg.sv
hw/dnc_shape_pkg.sv
hw/dnc_matrix_vector_product.sv
hw/dnc_vector_adder.sv
hw/dnc_output_vector.sv
testbench/dnc_output_vector_tb.sv
